// File: source/spi_cmd_pkg.sv
package spi_cmd_pkg;

	// ------------------------------
	// command byte values
	// ------------------------------

	localparam logic [7:0] cmd_buttons  = 8'd1;
	localparam logic [7:0] cmd_joy0     = 8'd2;
	localparam logic [7:0] cmd_joy1     = 8'd3;
	localparam logic [7:0] cmd_mouse    = 8'd4;
	localparam logic [7:0] cmd_keyboard = 8'd5;
	localparam logic [7:0] cmd_osd      = 8'd6;

	// ------------------------------
	// core identification
	// ------------------------------

	// shifted out on miso while the command byte comes in
	localparam logic [7:0] core_type_value = 8'ha5;

	// ------------------------------
	// bit counter marks
	// ------------------------------

	// each mark is the count value while the last bit of that byte is sampled
	localparam logic [5:0] bit_cmd_end   = 6'd7;
	localparam logic [5:0] bit_byte1_end = 6'd15;
	localparam logic [5:0] bit_byte2_end = 6'd23;
	localparam logic [5:0] bit_byte3_end = 6'd31;

endpackage

// File: source/input_event_pkg.sv
package input_event_pkg;

	// ------------------------------
	// event type codes
	// ------------------------------

	localparam logic [1:0] evt_mouse_x  = 2'b00;
	localparam logic [1:0] evt_mouse_y  = 2'b01;
	localparam logic [1:0] evt_keyboard = 2'b10;
	localparam logic [1:0] evt_osd      = 2'b11;

	// ------------------------------
	// consumer sizes
	// ------------------------------

	localparam int queue_depth = 8;
	localparam int queue_ptr_w = 3;

	localparam int motion_w = 10;

	// the motion sums saturate at -512 and +511 with ten bits
	localparam logic signed [motion_w-1:0] motion_max = (2 ** (motion_w - 1)) - 1;
	localparam logic signed [motion_w-1:0] motion_min = -(2 ** (motion_w - 1));

	// the same payload byte is a key code for the queue and a motion step for the mouse
	typedef union packed {
		logic [7:0]        scancode;
		logic signed [7:0] delta;
	} event_byte_t;

endpackage

// File: source/spi_cmd_receiver.sv
`timescale 1ns/1ps

module spi_cmd_receiver
	import spi_cmd_pkg::*;
	import input_event_pkg::*;
(
	input  logic        SPI_CLK,
	input  logic        rst_n,
	input  logic        spi_ss_io,
	input  logic        spi_mosi,
	output logic        spi_miso,
	output logic [5:0]  joy0,
	output logic [5:0]  joy1,
	output logic [1:0]  buttons,
	output logic [1:0]  switches,
	output logic [2:0]  mouse_buttons,
	output logic        evt_strobe,
	output logic [1:0]  evt_type,
	output event_byte_t evt_byte
);

	logic [6:0] sbuf;
	logic [7:0] cmd;
	logic [5:0] cnt;
	logic [7:0] rx_byte;

	// the byte completes with the bit on mosi right now
	assign rx_byte = {sbuf, spi_mosi};

	// ------------------------------
	// core type out on miso
	// ------------------------------

	// updated on the falling edge so the master samples a stable bit on the rising one
	always_ff @(negedge SPI_CLK or negedge rst_n) begin
		if (!rst_n) begin
			spi_miso <= 1'b0;
		end else if (cnt <= bit_cmd_end) begin
			spi_miso <= core_type_value[3'd7 - cnt[2:0]];
		end
	end

	// ------------------------------
	// shift, count and decode
	// ------------------------------

	always_ff @(posedge SPI_CLK or negedge rst_n) begin
		if (!rst_n) begin
			sbuf          <= '0;
			cmd           <= '0;
			cnt           <= '0;
			joy0          <= '0;
			joy1          <= '0;
			buttons       <= '0;
			switches      <= '0;
			mouse_buttons <= '0;
			evt_strobe    <= 1'b0;
			evt_type      <= evt_mouse_x;
			evt_byte      <= '0;
		end else begin
			evt_strobe <= 1'b0;

			if (spi_ss_io) begin
				cnt <= '0;
			end else begin
				sbuf <= rx_byte[6:0];

				// stop at 63 so an overlong transaction cannot wrap into the marks again
				if (cnt != 6'd63) begin
					cnt <= cnt + 6'd1;
				end

				if (cnt == bit_cmd_end) begin
					cmd <= rx_byte;
				end

				if (cnt == bit_byte1_end) begin
					case (cmd)
						cmd_buttons: begin
							buttons  <= rx_byte[1:0];
							switches <= rx_byte[3:2];
						end
						cmd_joy0: begin
							joy0 <= rx_byte[5:0];
						end
						cmd_joy1: begin
							joy1 <= rx_byte[5:0];
						end
						cmd_mouse: begin
							evt_strobe <= 1'b1;
							evt_type   <= evt_mouse_x;
							evt_byte   <= event_byte_t'(rx_byte);
						end
						cmd_keyboard: begin
							evt_strobe <= 1'b1;
							evt_type   <= evt_keyboard;
							evt_byte   <= event_byte_t'(rx_byte);
						end
						cmd_osd: begin
							evt_strobe <= 1'b1;
							evt_type   <= evt_osd;
							evt_byte   <= event_byte_t'(rx_byte);
						end
						default: begin
						end
					endcase
				end

				// mouse packets carry y and then the buttons after the x byte
				if (cmd == cmd_mouse && cnt == bit_byte2_end) begin
					evt_strobe <= 1'b1;
					evt_type   <= evt_mouse_y;
					evt_byte   <= event_byte_t'(rx_byte);
				end

				if (cmd == cmd_mouse && cnt == bit_byte3_end) begin
					mouse_buttons <= rx_byte[2:0];
				end
			end
		end
	end

	// the byte marks are eight bits apart, so the consumers never see back to back events
	assert property (@(posedge SPI_CLK) disable iff (!rst_n)
		evt_strobe |=> !evt_strobe);

endmodule

// File: source/scancode_queue.sv
`timescale 1ns/1ps

module scancode_queue
	import input_event_pkg::*;
(
	input  logic        SPI_CLK,
	input  logic        rst_n,
	input  logic        evt_strobe,
	input  logic [1:0]  evt_type,
	input  event_byte_t evt_byte,
	input  logic        kbd_rd,
	output logic [7:0]  kbd_code,
	output logic        kbd_osd,
	output logic        kbd_empty,
	output logic        kbd_overflow
);

	// each entry is the osd flag above the scancode
	logic [8:0]             entry_mem [queue_depth];
	logic [queue_ptr_w-1:0] wr_ptr;
	logic [queue_ptr_w-1:0] rd_ptr;
	logic [queue_ptr_w:0]   count;
	logic                   is_code;
	logic                   full;
	logic                   push;
	logic                   pop;

	// mouse events share the strobe but never enter the queue
	assign is_code = (evt_type == evt_keyboard) || (evt_type == evt_osd);
	assign full    = count == (queue_ptr_w + 1)'(queue_depth);
	assign push    = evt_strobe && is_code && !full;
	assign pop     = kbd_rd && !kbd_empty;

	assign kbd_empty = count == '0;
	assign kbd_code  = entry_mem[rd_ptr][7:0];
	assign kbd_osd   = entry_mem[rd_ptr][8];

	always_ff @(posedge SPI_CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < queue_depth; i++) begin
				entry_mem[i] <= '0;
			end
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			kbd_overflow <= 1'b0;
		end else begin
			if (push) begin
				entry_mem[wr_ptr] <= {evt_type == evt_osd, evt_byte.scancode};
				wr_ptr            <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
			// a code arriving while full is lost, and the core finds out here
			if (evt_strobe && is_code && full) begin
				kbd_overflow <= 1'b1;
			end
		end
	end

	assert property (@(posedge SPI_CLK) disable iff (!rst_n)
		count <= (queue_ptr_w + 1)'(queue_depth));

	// the core only reads while it sees an entry at the head
	assert property (@(posedge SPI_CLK) disable iff (!rst_n)
		kbd_rd |-> !kbd_empty);

endmodule

// File: source/mouse_accumulator.sv
`timescale 1ns/1ps

module mouse_accumulator
	import input_event_pkg::*;
(
	input  logic                       SPI_CLK,
	input  logic                       rst_n,
	input  logic                       evt_strobe,
	input  logic [1:0]                 evt_type,
	input  event_byte_t                evt_byte,
	input  logic                       mouse_rd,
	output logic signed [motion_w-1:0] mouse_x,
	output logic signed [motion_w-1:0] mouse_y
);

	logic signed [motion_w-1:0] delta_ext;
	logic                       x_hit;
	logic                       y_hit;

	function automatic logic signed [motion_w-1:0] sat_add(
		input logic signed [motion_w-1:0] acc,
		input logic signed [motion_w-1:0] step
	);
		logic signed [motion_w:0] sum;
		sum = {acc[motion_w-1], acc} + {step[motion_w-1], step};
		if (sum > motion_max) begin
			return motion_max;
		end else if (sum < motion_min) begin
			return motion_min;
		end
		return sum[motion_w-1:0];
	endfunction

	assign delta_ext = {{(motion_w - 8){evt_byte.delta[7]}}, evt_byte.delta};
	assign x_hit     = evt_strobe && (evt_type == evt_mouse_x);
	assign y_hit     = evt_strobe && (evt_type == evt_mouse_y);

	always_ff @(posedge SPI_CLK or negedge rst_n) begin
		if (!rst_n) begin
			mouse_x <= '0;
			mouse_y <= '0;
		end else if (mouse_rd) begin
			// motion arriving with the read starts the next sum
			mouse_x <= x_hit ? delta_ext : '0;
			mouse_y <= y_hit ? delta_ext : '0;
		end else begin
			if (x_hit) begin
				mouse_x <= sat_add(mouse_x, delta_ext);
			end
			if (y_hit) begin
				mouse_y <= sat_add(mouse_y, delta_ext);
			end
		end
	end

	// a step never moves a sum against its own sign, so the sums clamp and never wrap
	assert property (@(posedge SPI_CLK) disable iff (!rst_n)
		(x_hit && !mouse_rd) |=> ($past(delta_ext) >= 0) == (mouse_x >= $past(mouse_x)) ||
			mouse_x == $past(mouse_x));
	assert property (@(posedge SPI_CLK) disable iff (!rst_n)
		(y_hit && !mouse_rd) |=> ($past(delta_ext) >= 0) == (mouse_y >= $past(mouse_y)) ||
			mouse_y == $past(mouse_y));

endmodule

// File: source/input_hub_top.sv
`timescale 1ns/1ps

module input_hub_top
	import input_event_pkg::*;
(
	input  logic                       SPI_CLK,
	input  logic                       rst_n,
	input  logic                       spi_ss_io,
	input  logic                       spi_mosi,
	output logic                       spi_miso,
	output logic [5:0]                 joy0,
	output logic [5:0]                 joy1,
	output logic [1:0]                 buttons,
	output logic [1:0]                 switches,
	output logic [2:0]                 mouse_buttons,
	input  logic                       kbd_rd,
	output logic [7:0]                 kbd_code,
	output logic                       kbd_osd,
	output logic                       kbd_empty,
	output logic                       kbd_overflow,
	input  logic                       mouse_rd,
	output logic signed [motion_w-1:0] mouse_x,
	output logic signed [motion_w-1:0] mouse_y
);

	// event bus from the receiver, shared by both consumers
	logic        evt_strobe;
	logic [1:0]  evt_type;
	event_byte_t evt_byte;

	spi_cmd_receiver receiver_i (
		.SPI_CLK       (SPI_CLK),
		.rst_n         (rst_n),
		.spi_ss_io     (spi_ss_io),
		.spi_mosi      (spi_mosi),
		.spi_miso      (spi_miso),
		.joy0          (joy0),
		.joy1          (joy1),
		.buttons       (buttons),
		.switches      (switches),
		.mouse_buttons (mouse_buttons),
		.evt_strobe    (evt_strobe),
		.evt_type      (evt_type),
		.evt_byte      (evt_byte)
	);

	scancode_queue queue_i (
		.SPI_CLK      (SPI_CLK),
		.rst_n        (rst_n),
		.evt_strobe   (evt_strobe),
		.evt_type     (evt_type),
		.evt_byte     (evt_byte),
		.kbd_rd       (kbd_rd),
		.kbd_code     (kbd_code),
		.kbd_osd      (kbd_osd),
		.kbd_empty    (kbd_empty),
		.kbd_overflow (kbd_overflow)
	);

	mouse_accumulator mouse_i (
		.SPI_CLK    (SPI_CLK),
		.rst_n      (rst_n),
		.evt_strobe (evt_strobe),
		.evt_type   (evt_type),
		.evt_byte   (evt_byte),
		.mouse_rd   (mouse_rd),
		.mouse_x    (mouse_x),
		.mouse_y    (mouse_y)
	);

endmodule

// File: test/spi_host_tasks.svh
// ------------------------------
// spi master side
// ------------------------------

// every call starts and ends one time unit after a rising edge of SPI_CLK

// drives one mosi bit, lets the DUT sample it and returns the miso bit of that same edge
task automatic shift_bit(input logic mosi_bit, output logic miso_bit);
	spi_mosi = mosi_bit;
	@(posedge SPI_CLK);
	#1;
	miso_bit = spi_miso;
endtask

// sends a command byte and nbytes payload bytes msb first
// the first eight miso bits are collected as the core type
task automatic send_transaction(
	input  logic [7:0] cmd,
	input  logic [7:0] b1,
	input  logic [7:0] b2,
	input  logic [7:0] b3,
	input  int         nbytes,
	output logic [7:0] core_type
);
	logic [31:0] frame;
	logic        miso_bit;
	frame     = {cmd, b1, b2, b3};
	core_type = '0;
	spi_ss_io = 1'b0;
	for (int i = 0; i < 8 * (nbytes + 1); i++) begin
		shift_bit(frame[31], miso_bit);
		frame = frame << 1;
		if (i < 8)
			core_type = {core_type[6:0], miso_bit};
	end
	spi_ss_io = 1'b1;
	spi_mosi  = 1'b0;
endtask

// File: test/tb_input_hub.sv
`timescale 1ns/1ps

module tb_input_hub
	import spi_cmd_pkg::*;
	import input_event_pkg::*;
();

	logic                       SPI_CLK;
	logic                       rst_n;
	logic                       spi_ss_io;
	logic                       spi_mosi;
	logic                       kbd_rd;
	logic                       mouse_rd;
	logic                       spi_miso;
	logic [5:0]                 joy0;
	logic [5:0]                 joy1;
	logic [1:0]                 buttons;
	logic [1:0]                 switches;
	logic [2:0]                 mouse_buttons;
	logic [7:0]                 kbd_code;
	logic                       kbd_osd;
	logic                       kbd_empty;
	logic                       kbd_overflow;
	logic signed [motion_w-1:0] mouse_x;
	logic signed [motion_w-1:0] mouse_y;

	// ------------------------------
	// reference model
	// ------------------------------

	int         seed = 80;
	int         errors = 0;
	int         checks = 0;
	// each entry is the osd flag above the scancode
	logic [8:0] model_q [$];
	logic [5:0] exp_joy0 = '0;
	logic [5:0] exp_joy1 = '0;
	logic [1:0] exp_buttons = '0;
	logic [1:0] exp_switches = '0;
	logic [2:0] exp_mouse_buttons = '0;
	logic       exp_overflow = 1'b0;
	int         exp_x = 0;
	int         exp_y = 0;

	input_hub_top input_hub_top_i (.*);

	`include "spi_host_tasks.svh"

	initial begin
		SPI_CLK = 1'b0;
		forever #5 SPI_CLK = ~SPI_CLK;
	end

	task automatic next_cycle();
		@(posedge SPI_CLK);
		#1;
	endtask

	task automatic check(input string name, input int expected, input int actual);
		checks++;
		assert (actual == expected) else begin
			$display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic finish_run();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	endtask

	// the mouse sums clamp at -512 and +511
	function automatic int sat_sum(input int acc, input int delta);
		if (acc + delta > 511)
			return 511;
		if (acc + delta < -512)
			return -512;
		return acc + delta;
	endfunction

	task automatic check_state();
		check("joy0", int'(exp_joy0), int'(joy0));
		check("joy1", int'(exp_joy1), int'(joy1));
		check("buttons", int'(exp_buttons), int'(buttons));
		check("switches", int'(exp_switches), int'(switches));
		check("mouse_buttons", int'(exp_mouse_buttons), int'(mouse_buttons));
		check("mouse_x", exp_x, int'(mouse_x));
		check("mouse_y", exp_y, int'(mouse_y));
		check("kbd_empty", int'(model_q.size() == 0), int'(kbd_empty));
		check("kbd_overflow", int'(exp_overflow), int'(kbd_overflow));
	endtask

	// ------------------------------
	// transactions and reads
	// ------------------------------

	task automatic run_transaction(input logic [7:0] cmd);
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		logic [7:0] core_type;
		b1 = 8'($random(seed));
		b2 = 8'($random(seed));
		b3 = 8'($random(seed));
		// most mouse packets push x up and y down hard so both sums reach their limits
		if (cmd == cmd_mouse && (b3[7] || b3[6])) begin
			b1 = {4'h7, b1[3:0]};
			b2 = {4'h8, b2[3:0]};
		end
		send_transaction(cmd, b1, b2, b3, (cmd == cmd_mouse) ? 3 : 1, core_type);
		check("core_type", int'(core_type_value), int'(core_type));
		case (cmd)
			cmd_buttons: begin
				exp_buttons  = b1[1:0];
				exp_switches = b1[3:2];
			end
			cmd_joy0: exp_joy0 = b1[5:0];
			cmd_joy1: exp_joy1 = b1[5:0];
			cmd_mouse: begin
				exp_x             = sat_sum(exp_x, int'($signed(b1)));
				exp_y             = sat_sum(exp_y, int'($signed(b2)));
				exp_mouse_buttons = b3[2:0];
			end
			default: begin
				if (model_q.size() < queue_depth)
					model_q.push_back({cmd == cmd_osd, b1});
				else
					exp_overflow = 1'b1;
			end
		endcase
		// queue and mouse sums follow one edge after the last payload bit
		next_cycle();
		check_state();
	endtask

	task automatic pop_entry();
		logic [8:0] head;
		head = model_q.pop_front();
		check("kbd_code", int'(head[7:0]), int'(kbd_code));
		check("kbd_osd", int'(head[8]), int'(kbd_osd));
		kbd_rd = 1'b1;
		next_cycle();
		kbd_rd = 1'b0;
	endtask

	task automatic read_mouse();
		check("mouse_x before read", exp_x, int'(mouse_x));
		check("mouse_y before read", exp_y, int'(mouse_y));
		mouse_rd = 1'b1;
		next_cycle();
		mouse_rd = 1'b0;
		exp_x = 0;
		exp_y = 0;
	endtask

	task automatic drain_queue();
		int pops;
		pops = 0;
		while (!kbd_empty) begin
			if (pops == queue_depth + 1) begin
				$display("queue did not drain within %0d reads", pops);
				errors++;
				break;
			end else if (model_q.size() == 0) begin
				$display("queue holds an entry that the model never accepted");
				errors++;
				break;
			end else begin
				pop_entry();
				pops++;
			end
		end
		check("entries left in model", 0, model_q.size());
	endtask

	initial begin
		logic [7:0] cmd;
		rst_n     = 1'b0;
		spi_ss_io = 1'b1;
		spi_mosi  = 1'b0;
		kbd_rd    = 1'b0;
		mouse_rd  = 1'b0;
		repeat (2) @(posedge SPI_CLK);
		#1;
		rst_n = 1'b1;
		check_state();

		for (int t = 0; t < 200; t++) begin
			cmd = 8'(1 + $unsigned($random(seed)) % 6);
			run_transaction(cmd);
			if (model_q.size() != 0 && !kbd_empty && $random(seed) % 2 == 0)
				pop_entry();
			if ($random(seed) % 16 == 0)
				read_mouse();
		end

		// fill past the queue depth with no reads in between
		drain_queue();
		for (int k = 0; k < queue_depth + 3; k++)
			run_transaction(cmd_keyboard);
		check("kbd_overflow after fill", 1, int'(kbd_overflow));
		drain_queue();
		read_mouse();
		finish_run();
	end

endmodule

// File: input_hub.f
+incdir+test
source/spi_cmd_pkg.sv
source/input_event_pkg.sv
source/spi_cmd_receiver.sv
source/scancode_queue.sv
source/mouse_accumulator.sv
source/input_hub_top.sv
test/tb_input_hub.sv

// File: Makefile
# Verilator build and run of the input hub testbench

VERILATOR ?= verilator
TOP       ?= tb_input_hub
FILELIST  ?= input_hub.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
